//--- Makefile
# Verilator build and run for the 16x16 multiplier

VERILATOR  ?= verilator
TOP        ?= mul16_tb
RTL_TOP    ?= mul16_top
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Failing status when the log holds the fail message or lacks the pass message
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/cla_adder.sv
// WIDTH must be a multiple of 4 and the sum wraps with carry-in tied to zero
`timescale 1ns/10ps
`default_nettype none

module cla_adder #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0] x,
  input  logic [WIDTH-1:0] y,
  output logic [WIDTH-1:0] sum
);

  localparam int NG = WIDTH / 4;

  logic [WIDTH-1:0] p;
  logic [WIDTH-1:0] g;
  // Group propagate, generate and carry-in
  logic [NG-1:0]    gp;
  logic [NG-1:0]    gg;
  logic [NG-1:0]    gc;

  assign p = x ^ y;
  assign g = x & y;

  genvar k;

  for (k = 0; k < NG; k++) begin : g_group
    logic [3:0] lp;
    logic [3:0] lg;
    logic [3:0] c;

    assign lp = p[4*k+3:4*k];
    assign lg = g[4*k+3:4*k];

    assign gp[k] = &lp;
    assign gg[k] = lg[3]
                 | (lp[3] & lg[2])
                 | (lp[3] & lp[2] & lg[1])
                 | (lp[3] & lp[2] & lp[1] & lg[0]);

    // Local lookahead inside the group
    assign c[0] = gc[k];
    assign c[1] = lg[0] | (lp[0] & c[0]);
    assign c[2] = lg[1] | (lp[1] & lg[0]) | (lp[1] & lp[0] & c[0]);
    assign c[3] = lg[2] | (lp[2] & lg[1]) | (lp[2] & lp[1] & lg[0])
                | (lp[2] & lp[1] & lp[0] & c[0]);

    assign sum[4*k+3:4*k] = lp ^ c;
  end

  // Second level, each group carry as a flat sum of products
  always_comb begin : group_lookahead
    logic term;
    term = 1'b0;
    for (int n = 0; n < NG; n++) begin
      gc[n] = 1'b0;
      for (int m = 0; m < n; m++) begin
        term = gg[m];
        for (int q = m + 1; q < n; q++) begin
          term = term & gp[q];
        end
        gc[n] = gc[n] | term;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/mul16_top.sv
// Unsigned 16x16 multiply with one operation in flight under a four-phase req/ack handshake
`timescale 1ns/10ps
`default_nettype none

module mul16_top import mul_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  input  logic [OPERAND_W-1:0] a,
  input  logic [OPERAND_W-1:0] b,
  output logic                 ack,
  output logic [PRODUCT_W-1:0] product
);

  // Shared multiplier operands and result
  logic [HALF_W-1:0] mul_a;
  logic [HALF_W-1:0] mul_b;
  logic [PP_W-1:0]   mul_p;

  partial_if pp_bus ();

  mul_controller u_ctrl (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .a      (a),
    .b      (b),
    .ack    (ack),
    .mul_a  (mul_a),
    .mul_b  (mul_b),
    .mul_p  (mul_p),
    .pp_bus (pp_bus.ctrl)
  );

  // One array serves all four quarter products
  mul8_array #(
    .HALF_W (HALF_W)
  ) u_mul (
    .a (mul_a),
    .b (mul_b),
    .p (mul_p)
  );

  mul_accumulator #(
    .WIDTH (PRODUCT_W)
  ) u_acc (
    .clk     (clk),
    .rst     (rst),
    .pp_bus  (pp_bus.acc),
    .product (product)
  );

endmodule

`default_nettype wire

//--- logic/mul8_array.sv
// Exact unsigned array multiplier for HALF_W of 2 or more and purely combinational
`timescale 1ns/10ps
`default_nettype none

module mul8_array #(
  parameter int HALF_W = 8
) (
  input  logic [HALF_W-1:0]   a,
  input  logic [HALF_W-1:0]   b,
  output logic [2*HALF_W-1:0] p
);

  localparam int N = HALF_W;

  // AND terms, row i is a times b[i]
  logic [N-1:0] pp [N];
  // Sum outputs per row with a zero top bit for the next row's shift
  logic [N:0]   s_row [N];
  logic [N-1:0] c_row [1:N-1];
  // Carries of the final ripple row
  logic [N-1:0] rc;

  genvar i, j;

  for (i = 0; i < N; i++) begin : g_and_row
    for (j = 0; j < N; j++) begin : g_and_bit
      assign pp[i][j] = a[j] & b[i];
    end
  end

  assign s_row[0] = {1'b0, pp[0]};

  for (i = 1; i < N; i++) begin : g_row
    assign s_row[i][N] = 1'b0;
    for (j = 0; j < N; j++) begin : g_cell
      if (i == 1) begin : g_ha
        assign s_row[i][j] = pp[i][j] ^ s_row[i-1][j+1];
        assign c_row[i][j] = pp[i][j] & s_row[i-1][j+1];
      end else begin : g_fa
        assign s_row[i][j] = pp[i][j] ^ s_row[i-1][j+1] ^ c_row[i-1][j];
        assign c_row[i][j] = (pp[i][j] & s_row[i-1][j+1])
                           | (pp[i][j] & c_row[i-1][j])
                           | (s_row[i-1][j+1] & c_row[i-1][j]);
      end
    end
  end

  // Low half falls out of the array one bit per row
  for (i = 0; i < N; i++) begin : g_low
    assign p[i] = s_row[i][0];
  end

  // Ripple row merges the last sums and carries
  assign rc[0] = 1'b0;
  for (j = 0; j < N; j++) begin : g_ripple
    assign p[N+j] = s_row[N-1][j+1] ^ c_row[N-1][j] ^ rc[j];
    if (j < N - 1) begin : g_carry
      assign rc[j+1] = (s_row[N-1][j+1] & c_row[N-1][j])
                     | (s_row[N-1][j+1] & rc[j])
                     | (c_row[N-1][j] & rc[j]);
    end
  end

endmodule

`default_nettype wire

//--- logic/mul_accumulator.sv
// WIDTH must equal PRODUCT_W and steps must arrive in the order 0 1 2 3
`timescale 1ns/10ps
`default_nettype none

module mul_accumulator import mul_pkg::*; #(
  parameter int WIDTH = PRODUCT_W
) (
  input  logic                 clk,
  input  logic                 rst,
  partial_if.acc               pp_bus,
  output logic [PRODUCT_W-1:0] product
);

  product_word_u    acc_q;
  product_word_u    acc_d;
  logic [WIDTH-1:0] aligned_pp;
  logic [WIDTH-1:0] add_sum;

  // Cross products sit at bit offset HALF_W
  assign aligned_pp = {{(WIDTH - PP_W - HALF_W){1'b0}}, pp_bus.pp, {HALF_W{1'b0}}};

  cla_adder #(
    .WIDTH (WIDTH)
  ) u_add (
    .x   (acc_q.word),
    .y   (aligned_pp),
    .sum (add_sum)
  );

  always_comb begin
    acc_d = acc_q;
    if (pp_bus.first) begin
      acc_d.word      = '0;
      acc_d.halves[0] = pp_bus.pp;
    end else if (pp_bus.step == 2'd1) begin
      // hh lands directly in the upper half
      acc_d.halves[1] = pp_bus.pp;
    end else begin
      acc_d.word = add_sum;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      acc_q.word <= '0;
    end else if (pp_bus.pp_valid) begin
      acc_q <= acc_d;
    end
  end

  assign product = acc_q.word;

  a_step_order: assert property (@(posedge clk) disable iff (rst)
    pp_bus.pp_valid |-> (pp_bus.first ? (pp_bus.step == '0)
                                      : ($past(pp_bus.pp_valid) &&
                                         pp_bus.step == $past(pp_bus.step) + 2'd1)));

endmodule

`default_nettype wire

//--- logic/mul_controller.sv
// Requester must hold a and b stable while req is high and ack answers 4 cycles after the req sample
`timescale 1ns/10ps
`default_nettype none

module mul_controller import mul_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  input  logic [OPERAND_W-1:0] a,
  input  logic [OPERAND_W-1:0] b,
  output logic                 ack,
  output logic [HALF_W-1:0]    mul_a,
  output logic [HALF_W-1:0]    mul_b,
  input  logic [PP_W-1:0]      mul_p,
  partial_if.ctrl              pp_bus
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_BUSY = 2'd1;
  localparam logic [1:0] S_DONE = 2'd2;

  logic [1:0]           state_q;
  logic [STEP_W-1:0]    step_q;
  logic [OPERAND_W-1:0] a_q;
  logic [OPERAND_W-1:0] b_q;
  logic                 latch;
  logic                 last_step;

  assign latch     = (state_q == S_IDLE) && req;
  assign last_step = (step_q == STEP_W'(NUM_STEPS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      step_q  <= '0;
      ack     <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (req) begin
            state_q <= S_BUSY;
            step_q  <= '0;
          end
        end
        S_BUSY: begin
          step_q <= step_q + 1'b1;
          if (last_step) begin
            state_q <= S_DONE;
            ack     <= 1'b1;
          end
        end
        S_DONE: begin
          // Hold the result until the requester lets go
          if (!req) begin
            state_q <= S_IDLE;
            ack     <= 1'b0;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (latch) begin
      a_q <= a;
      b_q <= b;
    end
  end

  // Step order ll, hh, lh, hl
  always_comb begin
    case (step_q)
      2'd0: begin
        mul_a = a_q[HALF_W-1:0];
        mul_b = b_q[HALF_W-1:0];
      end
      2'd1: begin
        mul_a = a_q[OPERAND_W-1:HALF_W];
        mul_b = b_q[OPERAND_W-1:HALF_W];
      end
      2'd2: begin
        mul_a = a_q[HALF_W-1:0];
        mul_b = b_q[OPERAND_W-1:HALF_W];
      end
      default: begin
        mul_a = a_q[OPERAND_W-1:HALF_W];
        mul_b = b_q[HALF_W-1:0];
      end
    endcase
  end

  assign pp_bus.pp_valid = (state_q == S_BUSY);
  assign pp_bus.step     = step_q;
  assign pp_bus.pp       = mul_p;
  assign pp_bus.first    = (state_q == S_BUSY) && (step_q == '0);

  a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> $past(req));

  a_latch_in_idle: assert property (@(posedge clk) disable iff (rst)
    !$stable({a_q, b_q}) |-> $past(state_q == S_IDLE));

  a_four_steps: assert property (@(posedge clk) disable iff (rst)
    $rose(pp_bus.pp_valid) |-> pp_bus.pp_valid [*NUM_STEPS] ##1 !pp_bus.pp_valid);

endmodule

`default_nettype wire

//--- logic/mul_pkg.sv
// Widths are fixed for a 16x16 unsigned multiply built from four 8x8 quarter products
`default_nettype none

package mul_pkg;

  localparam int OPERAND_W = 16;
  localparam int HALF_W    = 8;
  localparam int PRODUCT_W = 32;
  localparam int PP_W      = 16;

  // Quarter products per operation
  localparam int NUM_STEPS = 4;
  localparam int STEP_W    = 2;

  // One product register, read as a full word or as two 16-bit halves
  typedef union packed {
    logic [PRODUCT_W-1:0]       word;
    logic [1:0][PP_W-1:0]       halves;
  } product_word_u;

endpackage

`default_nettype wire

//--- logic/partial_if.sv
// One quarter product per valid cycle and no back-pressure toward the controller
`timescale 1ns/10ps
`default_nettype none

interface partial_if import mul_pkg::*; ();

  // High on each cycle that carries a quarter product
  logic              pp_valid;
  logic [STEP_W-1:0] step;
  logic [PP_W-1:0]   pp;
  // Step 0 of an operation
  logic              first;

  modport ctrl (
    output pp_valid,
    output step,
    output pp,
    output first
  );

  modport acc (
    input pp_valid,
    input step,
    input pp,
    input first
  );

endinterface

`default_nettype wire

//--- test/mul16_tb.sv
// Expects ack exactly 4 cycles after the req sample and ends the run at a fixed cycle limit
`timescale 1ns/10ps
`default_nettype none

module mul16_tb import mul_pkg::*; ();

  localparam int          CLK_PERIOD   = 100;
  localparam int          DRIVE_DLY    = 10;
  localparam int          RESET_CYCLES = 4;
  localparam int          ACK_LATENCY  = 4;
  localparam int          NUM_RANDOM   = 200;
  localparam int          HOLD_CYCLES  = 20;
  localparam logic [31:0] SEED         = 32'h8b9d_a7b1;
  // About 210 handshakes of 8 cycles, doubled and rounded up
  localparam int          MAX_CYCLES   = 4000;

  logic                 clk;
  logic                 rst;
  logic                 req;
  logic [OPERAND_W-1:0] a;
  logic [OPERAND_W-1:0] b;
  logic                 ack;
  logic [PRODUCT_W-1:0] product;

  // Operands of the handshake in progress
  logic [OPERAND_W-1:0] exp_a;
  logic [OPERAND_W-1:0] exp_b;
  logic                 ack_last;
  int                   errors;
  int                   checks;
  int                   cycle_count;

  tb_clock #(
    .PERIOD (CLK_PERIOD)
  ) u_clk (
    .clk (clk)
  );

  mul16_top UUT (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .a       (a),
    .b       (b),
    .ack     (ack),
    .product (product)
  );

  function automatic logic [PRODUCT_W-1:0] ref_product(input logic [OPERAND_W-1:0] x,
                                                       input logic [OPERAND_W-1:0] y);
    return PRODUCT_W'(x) * PRODUCT_W'(y);
  endfunction

  // Compare on the falling edge after ack rises, when product is settled
  always @(negedge clk) begin
    if (ack && !ack_last) begin
      checks++;
      assert (product == ref_product(exp_a, exp_b)) else begin
        $display("MISMATCH product: a=%h b=%h got %h expected %h",
                 exp_a, exp_b, product, ref_product(exp_a, exp_b));
        errors++;
      end
    end
    ack_last = ack;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // One full four-phase handshake, req held for hold extra cycles after ack
  task automatic run_op(input logic [OPERAND_W-1:0] op_a, input logic [OPERAND_W-1:0] op_b,
                        input int hold);
    int                   waited;
    logic [PRODUCT_W-1:0] held;
    waited = 0;
    @(posedge clk);
    #DRIVE_DLY;
    a     = op_a;
    b     = op_b;
    exp_a = op_a;
    exp_b = op_b;
    req   = 1'b1;
    // Edge that samples req
    @(posedge clk);
    #DRIVE_DLY;
    while (!ack && waited < 2 * ACK_LATENCY) begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
    end
    checks++;
    assert (ack && waited == ACK_LATENCY) else begin
      $display("ack rose %0d cycles after the req sample (ack=%0b), expected %0d",
               waited, ack, ACK_LATENCY);
      errors++;
    end
    held = product;
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      #DRIVE_DLY;
      checks++;
      assert (ack) else begin
        $display("ack dropped while req was still high, cycle %0d of the hold", i);
        errors++;
      end
      checks++;
      assert (product == held) else begin
        $display("MISMATCH product while held: got %h expected %h", product, held);
        errors++;
      end
    end
    req = 1'b0;
    @(posedge clk);
    #DRIVE_DLY;
    checks++;
    assert (!ack) else begin
      $display("ack still high one cycle after req fell");
      errors++;
    end
  endtask

  task automatic abort_with_reset();
    @(posedge clk);
    #DRIVE_DLY;
    a     = 16'h1234;
    b     = 16'habcd;
    exp_a = a;
    exp_b = b;
    req   = 1'b1;
    // Two edges in, the controller is in the middle of its steps
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b1;
    req = 1'b0;
    // Ack would rise inside this window if the reset left the steps running
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      #DRIVE_DLY;
      checks++;
      assert (!ack) else begin
        $display("ack high on cycle %0d of a reset during a busy operation", i);
        errors++;
      end
    end
    rst = 1'b0;
    checks++;
    assert (!ack) else begin
      $display("ack high after a reset during a busy operation");
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_mark);
    $display("%s: %0d errors", name, errors - err_mark);
  endtask

  initial begin
    int                   err_mark;
    logic [OPERAND_W-1:0] ra;
    logic [OPERAND_W-1:0] rb;
    rst         = 1'b1;
    req         = 1'b0;
    a           = '0;
    b           = '0;
    exp_a       = '0;
    exp_b       = '0;
    ack_last    = 1'b0;
    errors      = 0;
    checks      = 0;
    cycle_count = 0;
    void'($urandom(SEED));

    err_mark = errors;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;
    checks++;
    assert (!ack) else begin
      $display("ack high after reset");
      errors++;
    end
    report_test("reset", err_mark);

    err_mark = errors;
    run_op(16'h0000, 16'h0000, 0);
    run_op(16'h0001, 16'hffff, 0);
    run_op(16'hffff, 16'hffff, 0);
    run_op(16'h00ff, 16'hff00, 0);
    run_op(16'h8000, 16'h8000, 0);
    report_test("corner operands", err_mark);

    err_mark = errors;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      ra = OPERAND_W'($urandom);
      rb = OPERAND_W'($urandom);
      run_op(ra, rb, 0);
    end
    report_test("random operands", err_mark);

    err_mark = errors;
    run_op(16'h0101, 16'h0202, 0);
    run_op(16'hfedc, 16'h0123, 1);
    run_op(16'h7fff, 16'h0002, 2);
    report_test("handshake latency", err_mark);

    err_mark = errors;
    run_op(16'hbeef, 16'hcafe, HOLD_CYCLES);
    report_test("back-pressure", err_mark);

    err_mark = errors;
    abort_with_reset();
    run_op(16'h5a5a, 16'ha5a5, 0);
    report_test("reset during operation", err_mark);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
// Free-running clock that starts low with PERIOD given in ns
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- vlog.f
logic/mul_pkg.sv
logic/partial_if.sv
logic/mul8_array.sv
logic/cla_adder.sv
logic/mul_controller.sv
logic/mul_accumulator.sv
logic/mul16_top.sv
test/tb_clock.sv
test/mul16_tb.sv
